/* common/id_macros.svh */
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

`define XLEN            64
`define INST_W          32
`define REG_NUM         32
`define REG_IDX_W       5

`define OPCODE_LOC      6:0
`define RD_LOC          11:7
`define FUNCT3_LOC      14:12
`define RS1_LOC         19:15
`define RS2_LOC         24:20
`define FUNCT7_LOC      31:25

`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011

`endif

/* common/id_pkg.sv */
`default_nettype none

`include "id_macros.svh"

package id_pkg;

    typedef logic [`XLEN-1:0]      data_t;
    typedef logic [`INST_W-1:0]    inst_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_type_e;

    typedef enum logic [2:0] {
        CMP_EQ,
        CMP_NE,
        CMP_LT,
        CMP_GE,
        CMP_LTU,
        CMP_GEU
    } comp_type_e;

    // Encoding matches funct3[1:0] of loads and stores.
    typedef enum logic [1:0] {
        LSU_BYTE,
        LSU_HALF,
        LSU_WORD,
        LSU_DOUBLE
    } lsu_size_e;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       alu_src_pc;      // Operand a is the pc.
        logic       alu_src_imm;     // Operand b is the immediate.
    } ex_ctrl_t;

    typedef struct packed {
        logic       mem_read;
        logic       mem_write;
        lsu_size_e  size;
        logic       load_unsigned;
    } mem_ctrl_t;

    typedef struct packed {
        logic       rd_en;
        reg_idx_t   rd_index;
        data_t      rd_data;
    } wb_port_t;

    typedef struct packed {
        logic       rs1_en;
        logic       rs2_en;
        logic       rd_en;
        imm_type_e  imm_type;
        comp_type_e comp_type;
        logic       inst_jump;
        logic       inst_branch;
        logic       jump_base_rs1;   // JALR adds to rs1.
        logic       inst_lui;
        ex_ctrl_t   ex;
        mem_ctrl_t  mem;
    } dec_ctrl_t;

endpackage

`default_nettype wire

/* id_stage/id_branchjudge.sv */
`timescale 1ns/1ps
`default_nettype none

module id_branchjudge (
    input  wire  id_pkg::comp_type_e  comp_type_i,
    input  wire  id_pkg::data_t       rs1_data_i,
    input  wire  id_pkg::data_t       rs2_data_i,
    output logic                      taken_o
);

    import id_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rs1_data_i == rs2_data_i);
    assign lt_s = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign lt_u = (rs1_data_i < rs2_data_i);

    always_comb begin
        case (comp_type_i)
            CMP_EQ:  taken_o = eq;
            CMP_NE:  taken_o = !eq;
            CMP_LT:  taken_o = lt_s;
            CMP_GE:  taken_o = !lt_s;
            CMP_LTU: taken_o = lt_u;
            CMP_GEU: taken_o = !lt_u;
            default: taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* id_stage/id_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module id_control (
    input  wire  id_pkg::inst_t     inst_i,
    output id_pkg::dec_ctrl_t       ctrl_o
);

    import id_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_reg_op;
    alu_op_e    arith_op;
    logic       arith_valid;
    comp_type_e br_comp;
    logic       br_valid;

    assign opcode    = inst_i[`OPCODE_LOC];
    assign funct3    = inst_i[`FUNCT3_LOC];
    assign funct7    = inst_i[`FUNCT7_LOC];
    assign is_reg_op = (opcode == `OPC_OP);

    // Shared by OP and OP_IMM.
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (is_reg_op && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase

        arith_valid = 1'b1;
        if (is_reg_op) begin
            arith_valid = (funct7 == 7'b0000000) ||
                          ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
        end else if (funct3 == 3'b001) begin
            arith_valid = (funct7[6:1] == 6'b000000);            // Six-bit shamt.
        end else if (funct3 == 3'b101) begin
            arith_valid = (funct7[6:1] == 6'b000000) || (funct7[6:1] == 6'b010000);
        end
    end

    always_comb begin
        br_valid = 1'b1;
        case (funct3)
            3'b000:  br_comp = CMP_EQ;
            3'b001:  br_comp = CMP_NE;
            3'b100:  br_comp = CMP_LT;
            3'b101:  br_comp = CMP_GE;
            3'b110:  br_comp = CMP_LTU;
            3'b111:  br_comp = CMP_GEU;
            default: begin
                br_comp  = CMP_EQ;
                br_valid = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl_o = '0;                                         // Undecoded is a bubble.
        case (opcode)
            `OPC_OP: if (arith_valid) begin
                ctrl_o.rs1_en    = 1'b1;
                ctrl_o.rs2_en    = 1'b1;
                ctrl_o.rd_en     = 1'b1;
                ctrl_o.ex.alu_op = arith_op;
            end
            `OPC_OP_IMM: if (arith_valid) begin
                ctrl_o.rs1_en         = 1'b1;
                ctrl_o.rd_en          = 1'b1;
                ctrl_o.imm_type       = IMM_I;
                ctrl_o.ex.alu_op      = arith_op;
                ctrl_o.ex.alu_src_imm = 1'b1;
            end
            `OPC_LUI: begin
                ctrl_o.rd_en    = 1'b1;
                ctrl_o.imm_type = IMM_U;
                ctrl_o.inst_lui = 1'b1;
            end
            `OPC_AUIPC: begin
                ctrl_o.rd_en          = 1'b1;
                ctrl_o.imm_type       = IMM_U;
                ctrl_o.ex.alu_src_pc  = 1'b1;
                ctrl_o.ex.alu_src_imm = 1'b1;
            end
            `OPC_JAL: begin
                ctrl_o.rd_en     = 1'b1;
                ctrl_o.imm_type  = IMM_J;
                ctrl_o.inst_jump = 1'b1;
            end
            `OPC_JALR: if (funct3 == 3'b000) begin
                ctrl_o.rs1_en        = 1'b1;
                ctrl_o.rd_en         = 1'b1;
                ctrl_o.imm_type      = IMM_I;
                ctrl_o.inst_jump     = 1'b1;
                ctrl_o.jump_base_rs1 = 1'b1;
            end
            `OPC_BRANCH: if (br_valid) begin
                ctrl_o.rs1_en      = 1'b1;
                ctrl_o.rs2_en      = 1'b1;
                ctrl_o.imm_type    = IMM_B;
                ctrl_o.comp_type   = br_comp;
                ctrl_o.inst_branch = 1'b1;
            end
            `OPC_LOAD: if (funct3 != 3'b111) begin
                ctrl_o.rs1_en            = 1'b1;
                ctrl_o.rd_en             = 1'b1;
                ctrl_o.imm_type          = IMM_I;
                ctrl_o.ex.alu_src_imm    = 1'b1;
                ctrl_o.mem.mem_read      = 1'b1;
                ctrl_o.mem.size          = lsu_size_e'(funct3[1:0]);
                ctrl_o.mem.load_unsigned = funct3[2];
            end
            `OPC_STORE: if (!funct3[2]) begin
                ctrl_o.rs1_en         = 1'b1;
                ctrl_o.rs2_en         = 1'b1;
                ctrl_o.imm_type       = IMM_S;
                ctrl_o.ex.alu_src_imm = 1'b1;
                ctrl_o.mem.mem_write  = 1'b1;
                ctrl_o.mem.size       = lsu_size_e'(funct3[1:0]);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* id_stage/id_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module id_forward (
    input  wire                     rs_en_i,
    input  wire  id_pkg::reg_idx_t  rs_index_i,
    input  wire  id_pkg::data_t     reg_data_i,
    input  wire  id_pkg::wb_port_t  id2ex_i,
    input  wire  id_pkg::wb_port_t  ex2mem_i,
    input  wire  id_pkg::wb_port_t  mem2wb_i,
    output id_pkg::data_t           rs_data_o
);

    logic fwd_ok;
    logic id2ex_hit;
    logic ex2mem_hit;
    logic mem2wb_hit;

    // x0 and unused operands never forward.
    assign fwd_ok     = rs_en_i && (rs_index_i != '0);

    assign id2ex_hit  = fwd_ok && id2ex_i.rd_en  && (id2ex_i.rd_index  == rs_index_i);
    assign ex2mem_hit = fwd_ok && ex2mem_i.rd_en && (ex2mem_i.rd_index == rs_index_i);
    assign mem2wb_hit = fwd_ok && mem2wb_i.rd_en && (mem2wb_i.rd_index == rs_index_i);

    // Newest producer wins.
    always_comb begin
        if (id2ex_hit) begin
            rs_data_o = id2ex_i.rd_data;
        end else if (ex2mem_hit) begin
            rs_data_o = ex2mem_i.rd_data;
        end else if (mem2wb_hit) begin
            rs_data_o = mem2wb_i.rd_data;            // Same-cycle write bypass.
        end else begin
            rs_data_o = reg_data_i;
        end
    end

endmodule

`default_nettype wire

/* id_stage/id_immgen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module id_immgen (
    input  wire  id_pkg::inst_t      inst_i,
    input  wire  id_pkg::imm_type_e  imm_type_i,
    output id_pkg::data_t            imm_o
);

    import id_pkg::*;

    logic sign;

    assign sign = inst_i[31];

    always_comb begin
        case (imm_type_i)
            IMM_I:   imm_o = {{(`XLEN-12){sign}}, inst_i[31:20]};
            IMM_S:   imm_o = {{(`XLEN-12){sign}}, inst_i[31:25], inst_i[11:7]};
            IMM_B:   imm_o = {{(`XLEN-13){sign}}, inst_i[31], inst_i[7],
                              inst_i[30:25], inst_i[11:8], 1'b0};
            IMM_U:   imm_o = {{(`XLEN-32){sign}}, inst_i[31:12], 12'b0};
            IMM_J:   imm_o = {{(`XLEN-21){sign}}, inst_i[31], inst_i[19:12],
                              inst_i[20], inst_i[30:21], 1'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* id_stage/id_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module id_regfile (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire                     inst_valid_i,
    input  wire                     rs1_en_i,
    input  wire                     rs2_en_i,
    input  wire  id_pkg::reg_idx_t  rs1_index_i,
    input  wire  id_pkg::reg_idx_t  rs2_index_i,
    input  wire  id_pkg::wb_port_t  wb_i,
    output id_pkg::data_t           rs1_data_o,
    output id_pkg::data_t           rs2_data_o
);

    import id_pkg::*;

    data_t regs [`REG_NUM];         // Entry 0 is never written.

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.rd_en && (wb_i.rd_index != '0)) begin
            regs[wb_i.rd_index] <= wb_i.rd_data;
        end
    end

    assign rs1_data_o = (inst_valid_i && rs1_en_i && (rs1_index_i != '0)) ?
                        regs[rs1_index_i] : '0;
    assign rs2_data_o = (inst_valid_i && rs2_en_i && (rs2_index_i != '0)) ?
                        regs[rs2_index_i] : '0;

endmodule

`default_nettype wire

/* id_stage/id_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module id_top (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire                     inst_valid_i,
    input  wire  id_pkg::inst_t     inst_i,
    input  wire  id_pkg::data_t     inst_addr_i,
    input  wire  id_pkg::data_t     nxt_inst_addr_i,
    input  wire  id_pkg::wb_port_t  id2ex_i,
    input  wire  id_pkg::wb_port_t  ex2mem_i,
    input  wire  id_pkg::wb_port_t  mem2wb_i,
    output id_pkg::reg_idx_t        rs1_index_o,
    output id_pkg::reg_idx_t        rs2_index_o,
    output id_pkg::reg_idx_t        rd_index_o,
    output logic                    rd_en_o,
    output id_pkg::ex_ctrl_t        ex_ctrl_o,
    output id_pkg::mem_ctrl_t       mem_ctrl_o,
    output id_pkg::data_t           rs1_data_o,
    output id_pkg::data_t           rs2_data_o,
    output id_pkg::data_t           imm_data_o,
    output id_pkg::data_t           rd_data_o,
    output id_pkg::data_t           inst_addr_o,
    output id_pkg::data_t           jumpbranch_addr_o,
    output logic                    jumpbranch_en_o
);

    import id_pkg::*;

    dec_ctrl_t ctrl;
    reg_idx_t  rs1_index;
    reg_idx_t  rs2_index;
    data_t     rf_rs1_data;
    data_t     rf_rs2_data;
    data_t     rs1_data;
    data_t     rs2_data;
    data_t     imm;
    data_t     jb_base;
    logic      taken;

    assign rs1_index = inst_i[`RS1_LOC];
    assign rs2_index = inst_i[`RS2_LOC];

    id_control id_control_inst (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    id_regfile id_regfile_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .rs1_en_i     (ctrl.rs1_en),
        .rs2_en_i     (ctrl.rs2_en),
        .rs1_index_i  (rs1_index),
        .rs2_index_i  (rs2_index),
        .wb_i         (mem2wb_i),
        .rs1_data_o   (rf_rs1_data),
        .rs2_data_o   (rf_rs2_data)
    );

    id_immgen id_immgen_inst (
        .inst_i     (inst_i),
        .imm_type_i (ctrl.imm_type),
        .imm_o      (imm)
    );

    id_forward id_forward_rs1_inst (
        .rs_en_i    (ctrl.rs1_en),
        .rs_index_i (rs1_index),
        .reg_data_i (rf_rs1_data),
        .id2ex_i    (id2ex_i),
        .ex2mem_i   (ex2mem_i),
        .mem2wb_i   (mem2wb_i),
        .rs_data_o  (rs1_data)
    );

    id_forward id_forward_rs2_inst (
        .rs_en_i    (ctrl.rs2_en),
        .rs_index_i (rs2_index),
        .reg_data_i (rf_rs2_data),
        .id2ex_i    (id2ex_i),
        .ex2mem_i   (ex2mem_i),
        .mem2wb_i   (mem2wb_i),
        .rs_data_o  (rs2_data)
    );

    id_branchjudge id_branchjudge_inst (
        .comp_type_i (ctrl.comp_type),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .taken_o     (taken)
    );

    // JALR keeps bit 0 of the sum.
    assign jb_base           = ctrl.jump_base_rs1 ? rs1_data : inst_addr_i;
    assign jumpbranch_addr_o = jb_base + imm;
    assign jumpbranch_en_o   = ctrl.inst_jump | (ctrl.inst_branch & taken);

    assign rd_data_o   = ctrl.inst_lui ? imm : nxt_inst_addr_i;     // Link address otherwise.
    assign rs1_index_o = rs1_index;
    assign rs2_index_o = rs2_index;
    assign rd_index_o  = inst_i[`RD_LOC];
    assign rd_en_o     = ctrl.rd_en;
    assign ex_ctrl_o   = ctrl.ex;
    assign mem_ctrl_o  = ctrl.mem;
    assign rs1_data_o  = rs1_data;
    assign rs2_data_o  = rs2_data;
    assign imm_data_o  = imm;
    assign inst_addr_o = inst_addr_i;

endmodule

`default_nettype wire

/* id_top.f */
+incdir+common
common/id_pkg.sv
id_stage/id_control.sv
id_stage/id_regfile.sv
id_stage/id_immgen.sv
id_stage/id_forward.sv
id_stage/id_branchjudge.sv
id_stage/id_top.sv
tb/id_top_chk.sv
tb/tb_id_top.sv

/* run.sh */
#!/bin/sh
# Build and run the decode-stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_id_top -f id_top.f \
    -o sim_id_top > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/sim_id_top > sim.log 2>&1 || true
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0

/* tb/id_top_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module id_top_chk (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire  id_pkg::inst_t     inst_i,
    input  wire  id_pkg::data_t     rd_data_o,
    input  wire  id_pkg::data_t     imm_data_o,
    input  wire  id_pkg::mem_ctrl_t mem_ctrl_o,
    input  wire                     jumpbranch_en_o,
    input  wire  id_pkg::reg_idx_t  rs1_index_o,
    input  wire  id_pkg::data_t     rs1_data_o
);

    lui_result_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        (inst_i[`OPCODE_LOC] == `OPC_LUI) |-> (rd_data_o == imm_data_o))
        else $error("LUI result differs from the U immediate.");

    mem_excl_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(mem_ctrl_o.mem_read && mem_ctrl_o.mem_write))
        else $error("Read and write set together.");

    nop_jump_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        (inst_i == '0) |-> !jumpbranch_en_o)
        else $error("Jump on an all-zero instruction.");

    x0_read_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        (rs1_index_o == '0) |-> (rs1_data_o == '0))
        else $error("x0 read is not zero.");

endmodule

bind id_top id_top_chk id_top_chk_inst (.*);

`default_nettype wire

/* tb/tb_id_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module tb_id_top;

    import id_pkg::*;

    typedef struct {
        inst_t     inst;
        data_t     pc;
        wb_port_t  id2ex;
        wb_port_t  ex2mem;
        wb_port_t  mem2wb;
        data_t     imm;
        ex_ctrl_t  ex;
        mem_ctrl_t mem;
    } entry_t;

    logic      clk;
    logic      rst_n_i;
    logic      inst_valid_i;
    inst_t     inst_i;
    data_t     inst_addr_i;
    data_t     nxt_inst_addr_i;
    wb_port_t  id2ex_i;
    wb_port_t  ex2mem_i;
    wb_port_t  mem2wb_i;
    reg_idx_t  rs1_index_o;
    reg_idx_t  rs2_index_o;
    reg_idx_t  rd_index_o;
    logic      rd_en_o;
    ex_ctrl_t  ex_ctrl_o;
    mem_ctrl_t mem_ctrl_o;
    data_t     rs1_data_o;
    data_t     rs2_data_o;
    data_t     imm_data_o;
    data_t     rd_data_o;
    data_t     inst_addr_o;
    data_t     jumpbranch_addr_o;
    logic      jumpbranch_en_o;

    entry_t    tbl[$];
    data_t     model [`REG_NUM];
    data_t     rv [32];
    logic [31:0] lcg_state;
    data_t     pc_next;
    wb_port_t  pend_id2ex;
    wb_port_t  pend_ex2mem;
    wb_port_t  pend_mem2wb;
    logic      table_ready;

    id_top id_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic wb_port_t wb(input logic en, input reg_idx_t idx, input data_t data);
        wb_port_t w;
        w.rd_en    = en;
        w.rd_index = idx;
        w.rd_data  = data;
        return w;
    endfunction

    function automatic ex_ctrl_t mk_ex(input alu_op_e op, input logic src_pc, input logic src_imm);
        ex_ctrl_t x;
        x.alu_op      = op;
        x.alu_src_pc  = src_pc;
        x.alu_src_imm = src_imm;
        return x;
    endfunction

    function automatic mem_ctrl_t mk_mem(input logic rd, input logic wr, input lsu_size_e size,
                                         input logic uns);
        mem_ctrl_t m;
        m.mem_read      = rd;
        m.mem_write     = wr;
        m.size          = size;
        m.load_unsigned = uns;
        return m;
    endfunction

    // Encoders for the instruction formats.
    function automatic inst_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic inst_t enc_i(input data_t imm, input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd, input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic inst_t enc_s(input data_t imm, input reg_idx_t rs2, input reg_idx_t rs1,
                                    input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
    endfunction

    function automatic inst_t enc_b(input data_t imm, input reg_idx_t rs2, input reg_idx_t rs1,
                                    input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic inst_t enc_u(input data_t imm, input reg_idx_t rd, input logic [6:0] op);
        return {imm[31:12], rd, op};
    endfunction

    function automatic inst_t enc_j(input data_t imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    task automatic add_entry(input inst_t inst, input data_t imm, input ex_ctrl_t ex,
                             input mem_ctrl_t mem);
        entry_t e;
        e.inst   = inst;
        e.pc     = pc_next;
        e.id2ex  = pend_id2ex;
        e.ex2mem = pend_ex2mem;
        e.mem2wb = pend_mem2wb;
        e.imm    = imm;
        e.ex     = ex;
        e.mem    = mem;
        tbl.push_back(e);
        pc_next     = pc_next + 4;
        pend_id2ex  = '0;
        pend_ex2mem = '0;
        pend_mem2wb = '0;
    endtask

    task automatic write_reg(input reg_idx_t idx, input data_t data);
        pend_mem2wb = wb(1'b1, idx, data);
        add_entry('0, '0, '0, '0);
    endtask

    // Newest producer first, then the register model.
    function automatic data_t ref_operand(input logic en, input reg_idx_t idx, input entry_t e);
        if (!en || idx == 0) return '0;
        if (e.id2ex.rd_en && e.id2ex.rd_index == idx) return e.id2ex.rd_data;
        if (e.ex2mem.rd_en && e.ex2mem.rd_index == idx) return e.ex2mem.rd_data;
        if (e.mem2wb.rd_en && e.mem2wb.rd_index == idx) return e.mem2wb.rd_data;
        return model[idx];
    endfunction

    function automatic logic ref_taken(input logic [2:0] f3, input data_t a, input data_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic report(input string name, input logic [63:0] exp, input logic [63:0] act);
        $display("ERR %s expected %h actual %h", name, exp, act);
        $display("Test failed");
        $fatal(1, "Output mismatch.");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) report(name, exp, act);
    endtask

    task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) report(name, 64'(exp), 64'(act));
    endtask

    task automatic check_ex(input string name, input ex_ctrl_t exp, input ex_ctrl_t act);
        if (act !== exp) report(name, 64'(exp), 64'(act));
    endtask

    task automatic check_mem(input string name, input mem_ctrl_t exp, input mem_ctrl_t act);
        if (act !== exp) report(name, 64'(exp), 64'(act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) report(name, 64'(exp), 64'(act));
    endtask

    task automatic build_table();
        ex_ctrl_t ex_imm;
        ex_imm = mk_ex(ALU_ADD, 1'b0, 1'b1);
        for (int i = 0; i < 32; i++) begin
            rv[i] = {lcg_next(), lcg_next()};
        end
        // Register writes and an ignored x0 write.
        write_reg(1, rv[1]);
        write_reg(2, rv[2]);
        write_reg(3, rv[3]);
        write_reg(0, rv[10]);
        write_reg(6, -128);
        write_reg(4, 5);
        add_entry(enc_r(7'h00, 2, 1, 3'b000, 7), '0, mk_ex(ALU_ADD, 0, 0), '0);
        add_entry(enc_r(7'h20, 4, 3, 3'b000, 8), '0, mk_ex(ALU_SUB, 0, 0), '0);
        add_entry(enc_r(7'h00, 1, 0, 3'b000, 9), '0, mk_ex(ALU_ADD, 0, 0), '0);
        // Forwarding priority.
        pend_id2ex  = wb(1, 1, rv[20]);
        pend_ex2mem = wb(1, 1, rv[21]);
        pend_mem2wb = wb(1, 1, rv[22]);
        add_entry(enc_r(7'h00, 2, 1, 3'b000, 10), '0, mk_ex(ALU_ADD, 0, 0), '0);
        pend_ex2mem = wb(1, 2, rv[23]);
        pend_mem2wb = wb(1, 2, rv[24]);
        add_entry(enc_r(7'h00, 2, 1, 3'b000, 10), '0, mk_ex(ALU_ADD, 0, 0), '0);
        pend_id2ex  = wb(0, 1, rv[25]);
        pend_ex2mem = wb(1, 1, rv[26]);
        add_entry(enc_r(7'h00, 2, 1, 3'b000, 10), '0, mk_ex(ALU_ADD, 0, 0), '0);
        pend_mem2wb = wb(1, 3, rv[27]);
        add_entry(enc_r(7'h00, 1, 3, 3'b000, 11), '0, mk_ex(ALU_ADD, 0, 0), '0);
        pend_id2ex = wb(1, 0, rv[28]);
        add_entry(enc_r(7'h00, 2, 0, 3'b000, 12), '0, mk_ex(ALU_ADD, 0, 0), '0);
        add_entry(enc_r(7'h00, 2, 1, 3'b000, 13), '0, mk_ex(ALU_ADD, 0, 0), '0);
        // Immediate ALU operations.
        add_entry(enc_i(-1, 2, 3'b000, 1, `OPC_OP_IMM), -1, ex_imm, '0);
        add_entry(enc_i(63, 3, 3'b001, 3, `OPC_OP_IMM), 63, mk_ex(ALU_SLL, 0, 1), '0);
        add_entry(enc_i('h405, 3, 3'b101, 3, `OPC_OP_IMM), 'h405, mk_ex(ALU_SRA, 0, 1), '0);
        add_entry(enc_i(2047, 2, 3'b011, 1, `OPC_OP_IMM), 2047, mk_ex(ALU_SLTU, 0, 1), '0);
        add_entry(enc_i(-2048, 2, 3'b100, 1, `OPC_OP_IMM), -2048, mk_ex(ALU_XOR, 0, 1), '0);
        // Stores and loads.
        add_entry(enc_s(-8, 2, 1, 3'b011), -8, ex_imm, mk_mem(0, 1, LSU_DOUBLE, 0));
        add_entry(enc_s(100, 2, 1, 3'b000), 100, ex_imm, mk_mem(0, 1, LSU_BYTE, 0));
        add_entry(enc_s(-2048, 4, 6, 3'b001), -2048, ex_imm, mk_mem(0, 1, LSU_HALF, 0));
        add_entry(enc_s(2047, 6, 4, 3'b010), 2047, ex_imm, mk_mem(0, 1, LSU_WORD, 0));
        add_entry(enc_i(-4, 1, 3'b000, 7, `OPC_LOAD), -4, ex_imm, mk_mem(1, 0, LSU_BYTE, 0));
        add_entry(enc_i(6, 1, 3'b101, 7, `OPC_LOAD), 6, ex_imm, mk_mem(1, 0, LSU_HALF, 1));
        add_entry(enc_i(12, 2, 3'b110, 7, `OPC_LOAD), 12, ex_imm, mk_mem(1, 0, LSU_WORD, 1));
        add_entry(enc_i(-16, 2, 3'b011, 7, `OPC_LOAD), -16, ex_imm, mk_mem(1, 0, LSU_DOUBLE, 0));
        // Every branch compare both taken and not taken.
        add_entry(enc_b(-16, 1, 1, 3'b000), -16, '0, '0);
        add_entry(enc_b(32, 2, 1, 3'b000), 32, '0, '0);
        add_entry(enc_b(-4096, 2, 1, 3'b001), -4096, '0, '0);
        add_entry(enc_b(4094, 1, 1, 3'b001), 4094, '0, '0);
        add_entry(enc_b(64, 4, 6, 3'b100), 64, '0, '0);
        add_entry(enc_b(64, 6, 4, 3'b100), 64, '0, '0);
        add_entry(enc_b(-8, 6, 4, 3'b101), -8, '0, '0);
        add_entry(enc_b(-8, 4, 6, 3'b101), -8, '0, '0);
        add_entry(enc_b(128, 4, 6, 3'b110), 128, '0, '0);
        add_entry(enc_b(128, 6, 4, 3'b110), 128, '0, '0);
        add_entry(enc_b(-256, 4, 6, 3'b111), -256, '0, '0);
        add_entry(enc_b(-256, 6, 4, 3'b111), -256, '0, '0);
        pend_id2ex = wb(1, 4, rv[30]);
        add_entry(enc_b(20, 6, 4, 3'b100), 20, '0, '0);
        // Jumps, LUI and AUIPC.
        add_entry(enc_j(-2048, 1), -2048, '0, '0);
        add_entry(enc_j('hffffe, 1), 'hffffe, '0, '0);
        add_entry(enc_i(3, 2, 3'b000, 1, `OPC_JALR), 3, '0, '0);
        pend_ex2mem = wb(1, 2, rv[31]);
        add_entry(enc_i(-5, 2, 3'b000, 1, `OPC_JALR), -5, '0, '0);
        add_entry(enc_u('h12345000, 5, `OPC_AUIPC), 'h12345000, mk_ex(ALU_ADD, 1, 1), '0);
        add_entry(enc_u(-4096, 5, `OPC_AUIPC), -4096, mk_ex(ALU_ADD, 1, 1), '0);
        add_entry(enc_u(64'hffff_ffff_8765_4000, 6, `OPC_LUI), 64'hffff_ffff_8765_4000, '0, '0);
        add_entry(enc_u('h7ffff000, 6, `OPC_LUI), 'h7ffff000, '0, '0);
    endtask

    task automatic run_entry(input entry_t e);
        logic [6:0] op;
        logic       en1;
        logic       en2;
        logic       rd_en;
        logic       jb_en;
        data_t      a;
        data_t      b;
        data_t      base;
        op    = e.inst[6:0];
        en1   = op inside {`OPC_OP, `OPC_OP_IMM, `OPC_JALR, `OPC_BRANCH, `OPC_LOAD, `OPC_STORE};
        en2   = op inside {`OPC_OP, `OPC_BRANCH, `OPC_STORE};
        rd_en = op inside {`OPC_OP, `OPC_OP_IMM, `OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR,
                           `OPC_LOAD};
        @(negedge clk);
        inst_i          = e.inst;
        inst_addr_i     = e.pc;
        nxt_inst_addr_i = e.pc + 4;
        id2ex_i         = e.id2ex;
        ex2mem_i        = e.ex2mem;
        mem2wb_i        = e.mem2wb;
        #1;
        a     = ref_operand(en1, e.inst[19:15], e);
        b     = ref_operand(en2, e.inst[24:20], e);
        jb_en = (op == `OPC_JAL) || (op == `OPC_JALR) ||
                ((op == `OPC_BRANCH) && ref_taken(e.inst[14:12], a, b));
        base  = (op == `OPC_JALR) ? a : e.pc;
        check_idx("rs1_index_o", e.inst[19:15], rs1_index_o);
        check_idx("rs2_index_o", e.inst[24:20], rs2_index_o);
        check_idx("rd_index_o", e.inst[11:7], rd_index_o);
        check_bit("rd_en_o", rd_en, rd_en_o);
        check_ex("ex_ctrl_o", e.ex, ex_ctrl_o);
        check_mem("mem_ctrl_o", e.mem, mem_ctrl_o);
        check_data("rs1_data_o", a, rs1_data_o);
        check_data("rs2_data_o", b, rs2_data_o);
        check_data("imm_data_o", e.imm, imm_data_o);
        check_data("rd_data_o", (op == `OPC_LUI) ? e.imm : e.pc + 4, rd_data_o);
        check_data("inst_addr_o", e.pc, inst_addr_o);
        check_bit("jumpbranch_en_o", jb_en, jumpbranch_en_o);
        check_data("jumpbranch_addr_o", base + e.imm, jumpbranch_addr_o);
        if (e.mem2wb.rd_en && e.mem2wb.rd_index != 0) begin
            model[e.mem2wb.rd_index] = e.mem2wb.rd_data;      // Taken at the next edge.
        end
    endtask

    initial begin
        wait (table_ready);
        #((10 + 4 * tbl.size()) * 8 + 100);
        $display("Timeout: the table did not finish in the expected time.");
        $display("Test failed");
        $fatal(1, "Watchdog expired.");
    end

    initial begin
        table_ready     = 1'b0;
        rst_n_i         = 1'b0;
        inst_valid_i    = 1'b1;
        inst_i          = '0;
        inst_addr_i     = '0;
        nxt_inst_addr_i = '0;
        id2ex_i         = '0;
        ex2mem_i        = '0;
        mem2wb_i        = '0;
        lcg_state       = 32'h9b91b52e;
        pc_next         = 64'h0000_0000_8000_0000;
        pend_id2ex      = '0;
        pend_ex2mem     = '0;
        pend_mem2wb     = '0;
        for (int i = 0; i < `REG_NUM; i++) begin
            model[i] = '0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        foreach (tbl[i]) begin
            run_entry(tbl[i]);
        end
        @(negedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
